// ==== common/lc4_isa_pkg.sv ====
package lc4_isa_pkg;

    localparam int WORD_W   = 16;
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0]           word_t;     // data, address or instruction
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [2:0]                  nzp_t;      // {n, z, p}

    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    // sub-opcodes live in insn[5:3]
    localparam logic [2:0] ARITH_ADD = 3'b000;
    localparam logic [2:0] ARITH_MUL = 3'b001;
    localparam logic [2:0] ARITH_SUB = 3'b010;
    localparam logic [2:0] LOGIC_AND = 3'b000;
    localparam logic [2:0] LOGIC_OR  = 3'b010;
    localparam logic [2:0] LOGIC_XOR = 3'b011;

    // field positions
    localparam int OP_HI   = 15;
    localparam int OP_LO   = 12;
    localparam int RD_HI   = 11;   // also the BR mask and the STR value register
    localparam int RD_LO   = 9;
    localparam int RS_HI   = 8;
    localparam int RS_LO   = 6;
    localparam int SUB_HI  = 5;
    localparam int SUB_LO  = 3;
    localparam int RT_HI   = 2;
    localparam int RT_LO   = 0;
    localparam int IMM_SEL = 5;    // ADD with imm5 when set

    // condition bits of a value written back
    function automatic nzp_t nzp_of(input word_t value);
        if (value[WORD_W-1])
            return 3'b100;
        else if (value == '0)
            return 3'b010;
        return 3'b001;
    endfunction

endpackage

// ==== common/lc4_pipe_pkg.sv ====
package lc4_pipe_pkg;

    // decoded control, built in D and carried with the instruction
    typedef struct packed {
        lc4_isa_pkg::reg_idx_t rs_sel;
        lc4_isa_pkg::reg_idx_t rt_sel;
        lc4_isa_pkg::reg_idx_t rd_sel;
        logic                  rs_re;
        logic                  rt_re;
        logic                  rf_we;
        logic                  nzp_we;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;   // only set for a non-empty mask
    } ctrl_t;

    // retire stall code, flush doubles as the empty slot after reset
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_t;

    typedef struct packed {
        lc4_isa_pkg::word_t pc;
        lc4_isa_pkg::word_t insn;
        ctrl_t              ctrl;
        stall_t             stall;
    } stage_t;

    typedef struct packed {
        stall_t                stall;
        lc4_isa_pkg::word_t    pc;
        lc4_isa_pkg::word_t    insn;
        logic                  rf_we;
        lc4_isa_pkg::reg_idx_t rf_wsel;
        lc4_isa_pkg::word_t    rf_data;
        logic                  nzp_we;
        lc4_isa_pkg::nzp_t     nzp;
        logic                  dmem_we;
        lc4_isa_pkg::word_t    dmem_addr;
        lc4_isa_pkg::word_t    dmem_data;   // load data or store data
    } retire_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_M   = 2'd1,
        FWD_W   = 2'd2
    } fwd_sel_t;

endpackage

// ==== hw/lc4_decoder.sv ====
`timescale 1ns/100ps

module lc4_decoder (
    input  lc4_isa_pkg::word_t  i_insn,
    output lc4_pipe_pkg::ctrl_t o_ctrl
);

    lc4_isa_pkg::opcode_t  opcode;
    logic [2:0]            sub_op;
    lc4_isa_pkg::reg_idx_t f_d;    // rd, BR mask or STR value register
    lc4_isa_pkg::reg_idx_t f_s;
    lc4_isa_pkg::reg_idx_t f_t;
    logic                  arith_ok;
    logic                  logic_ok;

    assign opcode = lc4_isa_pkg::opcode_t'(i_insn[lc4_isa_pkg::OP_HI:lc4_isa_pkg::OP_LO]);
    assign sub_op = i_insn[lc4_isa_pkg::SUB_HI:lc4_isa_pkg::SUB_LO];
    assign f_d    = i_insn[lc4_isa_pkg::RD_HI:lc4_isa_pkg::RD_LO];
    assign f_s    = i_insn[lc4_isa_pkg::RS_HI:lc4_isa_pkg::RS_LO];
    assign f_t    = i_insn[lc4_isa_pkg::RT_HI:lc4_isa_pkg::RT_LO];

    // DIV, MOD, NOT and AND-imm fall through as no-ops
    assign arith_ok = i_insn[lc4_isa_pkg::IMM_SEL] ||
                      sub_op inside {lc4_isa_pkg::ARITH_ADD, lc4_isa_pkg::ARITH_MUL,
                                     lc4_isa_pkg::ARITH_SUB};
    assign logic_ok = sub_op inside {lc4_isa_pkg::LOGIC_AND, lc4_isa_pkg::LOGIC_OR,
                                     lc4_isa_pkg::LOGIC_XOR};

    always_comb begin
        o_ctrl = '0;
        case (opcode)
            lc4_isa_pkg::OP_BR: begin
                o_ctrl.is_branch = (f_d != '0);    // empty mask is a nop
            end
            lc4_isa_pkg::OP_ARITH, lc4_isa_pkg::OP_LOGIC: begin
                if (opcode == lc4_isa_pkg::OP_ARITH ? arith_ok : logic_ok) begin
                    o_ctrl.rs_sel = f_s;
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_sel = f_t;
                    o_ctrl.rt_re  = !(opcode == lc4_isa_pkg::OP_ARITH &&
                                      i_insn[lc4_isa_pkg::IMM_SEL]);
                    o_ctrl.rd_sel = f_d;
                    o_ctrl.rf_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            lc4_isa_pkg::OP_LDR: begin
                o_ctrl.rs_sel  = f_s;
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_sel  = f_d;
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            lc4_isa_pkg::OP_STR: begin
                o_ctrl.rs_sel   = f_s;     // base
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_sel   = f_d;     // value to store
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            lc4_isa_pkg::OP_CONST: begin
                o_ctrl.rd_sel = f_d;
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            default: o_ctrl = '0;
        endcase
    end

endmodule

// ==== hw/lc4_alu.sv ====
`timescale 1ns/100ps

module lc4_alu (
    input  lc4_isa_pkg::word_t i_insn,
    input  lc4_isa_pkg::word_t i_pc,
    input  lc4_isa_pkg::word_t i_rs,
    input  lc4_isa_pkg::word_t i_rt,
    output lc4_isa_pkg::word_t o_result
);

    lc4_isa_pkg::opcode_t opcode;
    logic [2:0]           sub_op;
    lc4_isa_pkg::word_t   imm5;
    lc4_isa_pkg::word_t   imm6;
    lc4_isa_pkg::word_t   imm9;

    assign opcode = lc4_isa_pkg::opcode_t'(i_insn[lc4_isa_pkg::OP_HI:lc4_isa_pkg::OP_LO]);
    assign sub_op = i_insn[lc4_isa_pkg::SUB_HI:lc4_isa_pkg::SUB_LO];
    assign imm5   = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6   = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9   = {{7{i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (opcode)
            lc4_isa_pkg::OP_BR:    o_result = i_pc + 16'd1 + imm9;    // taken target
            lc4_isa_pkg::OP_ARITH: begin
                if (i_insn[lc4_isa_pkg::IMM_SEL])
                    o_result = i_rs + imm5;
                else if (sub_op == lc4_isa_pkg::ARITH_MUL)
                    o_result = i_rs * i_rt;
                else if (sub_op == lc4_isa_pkg::ARITH_SUB)
                    o_result = i_rs - i_rt;
                else
                    o_result = i_rs + i_rt;
            end
            lc4_isa_pkg::OP_LOGIC: begin
                case (sub_op)
                    lc4_isa_pkg::LOGIC_OR:  o_result = i_rs | i_rt;
                    lc4_isa_pkg::LOGIC_XOR: o_result = i_rs ^ i_rt;
                    default:                o_result = i_rs & i_rt;
                endcase
            end
            lc4_isa_pkg::OP_LDR, lc4_isa_pkg::OP_STR: o_result = i_rs + imm6;   // address
            lc4_isa_pkg::OP_CONST: o_result = imm9;
            default:               o_result = '0;
        endcase
    end

endmodule

// ==== hw/lc4_regfile.sv ====
`timescale 1ns/100ps

module lc4_regfile (
    input  logic                  gwe,
    input  logic                  i_rst,
    input  lc4_isa_pkg::reg_idx_t i_rs_sel,
    input  lc4_isa_pkg::reg_idx_t i_rt_sel,
    output lc4_isa_pkg::word_t    o_rs_data,
    output lc4_isa_pkg::word_t    o_rt_data,
    input  lc4_isa_pkg::reg_idx_t i_wsel,
    input  logic                  i_we,
    input  lc4_isa_pkg::word_t    i_wdata
);

    lc4_isa_pkg::word_t regs [lc4_isa_pkg::NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < lc4_isa_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // same-cycle write shows through to D
    assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

    // a W-stage write must carry defined data from the bypass and writeback muxes
    a_wdata_known: assert property (@(posedge gwe) disable iff (i_rst)
        i_we |-> !$isunknown(i_wdata));

endmodule

// ==== lc4_core/lc4_hazard_unit.sv ====
`timescale 1ns/100ps

module lc4_hazard_unit (
    input  lc4_pipe_pkg::ctrl_t    i_d_ctrl,
    input  lc4_pipe_pkg::ctrl_t    i_x_ctrl,
    input  lc4_pipe_pkg::ctrl_t    i_m_ctrl,
    input  lc4_pipe_pkg::ctrl_t    i_w_ctrl,
    output lc4_pipe_pkg::fwd_sel_t o_rs_fwd,
    output lc4_pipe_pkg::fwd_sel_t o_rt_fwd,
    output logic                   o_wm_fwd,
    output logic                   o_load_stall
);

    logic m_in_o;    // M result sits in O, a load has nothing there yet

    // M beats W, the younger producer wins
    function automatic lc4_pipe_pkg::fwd_sel_t pick_src(input logic re,
                                                        input lc4_isa_pkg::reg_idx_t sel);
        if (re && m_in_o && i_m_ctrl.rd_sel == sel)
            return lc4_pipe_pkg::FWD_M;
        else if (re && i_w_ctrl.rf_we && i_w_ctrl.rd_sel == sel)
            return lc4_pipe_pkg::FWD_W;
        return lc4_pipe_pkg::FWD_REG;
    endfunction

    assign m_in_o = i_m_ctrl.rf_we && !i_m_ctrl.is_load;

    always_comb begin
        o_rs_fwd = pick_src(i_x_ctrl.rs_re, i_x_ctrl.rs_sel);
        o_rt_fwd = pick_src(i_x_ctrl.rt_re, i_x_ctrl.rt_sel);
    end

    // store data in M picked up from the W writeback
    assign o_wm_fwd = i_m_ctrl.is_store && i_w_ctrl.rf_we &&
                      i_w_ctrl.rd_sel == i_m_ctrl.rt_sel;

    // store data can wait for WM, a branch needs the load's NZP
    assign o_load_stall = i_x_ctrl.is_load &&
                          ((i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.rd_sel) ||
                           (i_d_ctrl.rt_re && i_d_ctrl.rt_sel == i_x_ctrl.rd_sel &&
                            !i_d_ctrl.is_store) ||
                           i_d_ctrl.is_branch);

endmodule

// ==== lc4_core/lc4_core.sv ====
`timescale 1ns/100ps

module lc4_core #(
    parameter lc4_isa_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic                  gwe,
    input  logic                  i_rst,
    output lc4_isa_pkg::word_t    o_imem_addr,
    input  lc4_isa_pkg::word_t    i_imem_data,
    output lc4_isa_pkg::word_t    o_dmem_addr,
    output logic                  o_dmem_we,
    output lc4_isa_pkg::word_t    o_dmem_wdata,
    input  lc4_isa_pkg::word_t    i_dmem_rdata,
    output lc4_pipe_pkg::retire_t o_retire
);

    localparam lc4_pipe_pkg::stage_t EMPTY_STAGE = '{pc: '0, insn: '0, ctrl: '0,
                                                     stall: lc4_pipe_pkg::STALL_FLUSH};
    localparam lc4_pipe_pkg::stage_t LOAD_STAGE  = '{pc: '0, insn: '0, ctrl: '0,
                                                     stall: lc4_pipe_pkg::STALL_LOAD};

    lc4_isa_pkg::word_t     pc_q;
    lc4_pipe_pkg::stage_t   d_q, d_rec, x_q, m_q, w_q;
    lc4_pipe_pkg::ctrl_t    dec_ctrl;
    lc4_isa_pkg::word_t     rf_rs, rf_rt;
    lc4_isa_pkg::word_t     a_q, b_q;       // X operands
    lc4_isa_pkg::word_t     o_q, bm_q;      // M result and store data
    lc4_isa_pkg::word_t     wo_q, wd_q;     // W result and memory data
    lc4_isa_pkg::word_t     rs_val, rt_val, alu_out, st_data, w_data;
    lc4_isa_pkg::nzp_t      nzp_q;
    lc4_pipe_pkg::fwd_sel_t rs_fwd, rt_fwd;
    logic                   wm_fwd, load_stall, br_taken, m_mem, w_mem;

    function automatic lc4_isa_pkg::word_t fwd_mux(input lc4_pipe_pkg::fwd_sel_t sel,
                                                   input lc4_isa_pkg::word_t reg_val);
        case (sel)
            lc4_pipe_pkg::FWD_M: return o_q;      // MX
            lc4_pipe_pkg::FWD_W: return w_data;   // WX
            default:             return reg_val;
        endcase
    endfunction

    assign o_imem_addr = pc_q;

    lc4_decoder u_decoder (.i_insn(d_q.insn), .o_ctrl(dec_ctrl));

    always_comb begin
        d_rec      = d_q;
        d_rec.ctrl = dec_ctrl;
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs_sel  (d_rec.ctrl.rs_sel),
        .i_rt_sel  (d_rec.ctrl.rt_sel),
        .o_rs_data (rf_rs),
        .o_rt_data (rf_rt),
        .i_wsel    (w_q.ctrl.rd_sel),
        .i_we      (w_q.ctrl.rf_we),
        .i_wdata   (w_data)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl     (d_rec.ctrl),
        .i_x_ctrl     (x_q.ctrl),
        .i_m_ctrl     (m_q.ctrl),
        .i_w_ctrl     (w_q.ctrl),
        .o_rs_fwd     (rs_fwd),
        .o_rt_fwd     (rt_fwd),
        .o_wm_fwd     (wm_fwd),
        .o_load_stall (load_stall)
    );

    always_comb begin
        rs_val = fwd_mux(rs_fwd, a_q);
        rt_val = fwd_mux(rt_fwd, b_q);
    end

    lc4_alu u_alu (.i_insn(x_q.insn), .i_pc(x_q.pc), .i_rs(rs_val), .i_rt(rt_val),
                   .o_result(alu_out));

    // BR mask shares the rd field
    assign br_taken = x_q.ctrl.is_branch &&
                      ((nzp_q & x_q.insn[lc4_isa_pkg::RD_HI:lc4_isa_pkg::RD_LO]) != '0);

    assign m_mem        = m_q.ctrl.is_load || m_q.ctrl.is_store;
    assign st_data      = wm_fwd ? w_data : bm_q;     // WM bypass
    assign o_dmem_addr  = m_mem ? o_q : '0;
    assign o_dmem_we    = m_q.ctrl.is_store;
    assign o_dmem_wdata = st_data;

    assign w_mem  = w_q.ctrl.is_load || w_q.ctrl.is_store;
    assign w_data = w_q.ctrl.is_load ? wd_q : wo_q;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q  <= RESET_PC;
            d_q   <= EMPTY_STAGE;
            x_q   <= EMPTY_STAGE;
            m_q   <= EMPTY_STAGE;
            w_q   <= EMPTY_STAGE;
            nzp_q <= '0;
        end else begin
            m_q <= x_q;
            w_q <= m_q;
            if (br_taken) begin               // flush wins over a load stall
                pc_q <= alu_out;
                d_q  <= EMPTY_STAGE;
                x_q  <= EMPTY_STAGE;
            end else if (load_stall) begin    // pc and D hold
                x_q <= LOAD_STAGE;
            end else begin
                pc_q <= pc_q + 16'd1;
                d_q  <= '{pc: pc_q, insn: i_imem_data, ctrl: '0,
                          stall: lc4_pipe_pkg::STALL_NONE};
                x_q  <= d_rec;
            end
            // younger X writer beats the load sitting in M
            if (x_q.ctrl.nzp_we && !x_q.ctrl.is_load)
                nzp_q <= lc4_isa_pkg::nzp_of(alu_out);
            else if (m_q.ctrl.is_load)
                nzp_q <= lc4_isa_pkg::nzp_of(i_dmem_rdata);
        end
    end

    always_ff @(posedge gwe) begin
        a_q  <= rf_rs;
        b_q  <= rf_rt;
        o_q  <= alu_out;
        bm_q <= rt_val;
        wo_q <= o_q;
        wd_q <= m_q.ctrl.is_store ? st_data : i_dmem_rdata;
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_retire <= '{stall: lc4_pipe_pkg::STALL_FLUSH, default: '0};
        end else begin
            o_retire.stall     <= w_q.stall;
            o_retire.pc        <= w_q.pc;
            o_retire.insn      <= w_q.insn;
            o_retire.rf_we     <= w_q.ctrl.rf_we;
            o_retire.rf_wsel   <= w_q.ctrl.rd_sel;
            o_retire.rf_data   <= w_data;
            o_retire.nzp_we    <= w_q.ctrl.nzp_we;
            o_retire.nzp       <= w_q.ctrl.nzp_we ? lc4_isa_pkg::nzp_of(w_data) : '0;
            o_retire.dmem_we   <= w_q.ctrl.is_store;
            o_retire.dmem_addr <= w_mem ? wo_q : '0;
            o_retire.dmem_data <= w_mem ? wd_q : '0;
        end
    end

    // only a live store may reach the data memory
    a_store_live: assert property (@(posedge gwe) disable iff (i_rst)
        o_dmem_we |-> m_q.stall == lc4_pipe_pkg::STALL_NONE);

endmodule

// ==== verification/lc4_core_model.svh ====
`ifndef LC4_CORE_MODEL_SVH
`define LC4_CORE_MODEL_SVH

// instruction-level interpreter, one call per instruction in program order
lc4_isa_pkg::word_t m_regs [8];
lc4_isa_pkg::word_t m_mem [65536];
logic [2:0]         m_nzp;
lc4_isa_pkg::word_t m_pc;

function automatic logic [2:0] sign_bits(input logic [15:0] v);
    if (v[15])
        return 3'b100;
    if (v == 16'h0000)
        return 3'b010;
    return 3'b001;
endfunction

// low bits of v as a signed field of the given width
function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
    logic signed [15:0] t;
    t = v << (16 - bits);
    return t >>> (16 - bits);
endfunction

task automatic model_step(input logic [15:0] insn, output lc4_pipe_pkg::retire_t rec,
                          output logic taken);
    logic [3:0]  op;
    logic [2:0]  d, s, t, sub;
    logic [15:0] rs, rt, res, addr;
    logic        wr;
    op   = insn[15:12];
    d    = insn[11:9];
    s    = insn[8:6];
    t    = insn[2:0];
    sub  = insn[5:3];
    rs   = m_regs[s];
    rt   = m_regs[t];
    rec  = '0;
    rec.stall = lc4_pipe_pkg::STALL_NONE;
    rec.pc    = m_pc;
    rec.insn  = insn;
    taken = 1'b0;
    wr    = 1'b0;
    res   = 16'h0000;
    case (op)
        4'h0: taken = (m_nzp & d) != 3'b000;     // empty mask never taken
        4'h1: begin
            wr = 1'b1;
            if (insn[5])
                res = rs + sext(insn, 5);
            else if (sub == 3'd1)
                res = rs * rt;
            else if (sub == 3'd2)
                res = rs - rt;
            else
                res = rs + rt;
        end
        4'h5: begin
            wr = 1'b1;
            res = (sub == 3'd2) ? (rs | rt) : (sub == 3'd3) ? (rs ^ rt) : (rs & rt);
        end
        4'h6: begin
            wr   = 1'b1;
            addr = rs + sext(insn, 6);
            res  = m_mem[addr];
            rec.dmem_addr = addr;
            rec.dmem_data = res;
        end
        4'h7: begin
            addr = rs + sext(insn, 6);
            m_mem[addr]   = m_regs[d];    // value register sits in the rd field
            rec.dmem_we   = 1'b1;
            rec.dmem_addr = addr;
            rec.dmem_data = m_regs[d];
        end
        4'h9: begin
            wr  = 1'b1;
            res = sext(insn, 9);
        end
        default: wr = 1'b0;
    endcase
    if (wr) begin
        m_regs[d]   = res;
        m_nzp       = sign_bits(res);
        rec.rf_we   = 1'b1;
        rec.rf_wsel = d;
        rec.rf_data = res;
        rec.nzp_we  = 1'b1;
        rec.nzp     = sign_bits(res);
    end
    m_pc = taken ? m_pc + 16'd1 + sext(insn, 9) : m_pc + 16'd1;
endtask

`endif

// ==== verification/lc4_core_tb.sv ====
`timescale 1ns/100ps

module lc4_core_tb;

    localparam logic [15:0] RESET_PC = 16'h8200;
    localparam int PROG_LEN          = 200;
    localparam int RETIRE_TIMEOUT    = 50;

    logic                  gwe;
    logic                  i_rst;
    logic [15:0]           imem_addr, imem_data, imem_off;
    logic [15:0]           dmem_addr, dmem_wdata, dmem_rdata;
    logic                  dmem_we;
    lc4_pipe_pkg::retire_t retire;

    logic [15:0] prog [256];
    logic [15:0] dmem [65536];
    integer      seed;
    int          grp_chk [6];
    int          grp_err [6];
    bit          timed_out;

    lc4_pipe_pkg::retire_t exp_q [$];
    int                    exp_flush [$];
    int                    exp_load [$];

    `include "lc4_core_model.svh"

    lc4_core #(.RESET_PC(RESET_PC)) i_dut (
        .gwe          (gwe),
        .i_rst        (i_rst),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    assign imem_off   = imem_addr - RESET_PC;
    assign imem_data  = (imem_off < 16'(PROG_LEN)) ? prog[imem_off[7:0]] : 16'h0000;
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we)
            dmem[dmem_addr] <= dmem_wdata;
    end

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    task automatic check_val(input int grp, input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
        grp_chk[grp]++;
        assert (act_v === exp_v)
            else begin
                $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
                grp_err[grp]++;
            end
    endtask

    task automatic check_cond(input int grp, input bit cond, input string what);
        grp_chk[grp]++;
        assert (cond)
            else begin
                $display("error at %0t: %s", $time, what);
                grp_err[grp]++;
            end
    endtask

    // does insn read register r in D, by the load-use rules of the core
    function automatic bit reads_reg(input logic [15:0] insn, input logic [2:0] r);
        case (insn[15:12])
            4'h0:         return insn[11:9] != 3'b000;
            4'h1:         return insn[8:6] == r || (!insn[5] && insn[2:0] == r);
            4'h5:         return insn[8:6] == r || insn[2:0] == r;
            4'h6, 4'h7:   return insn[8:6] == r;
            default:      return 1'b0;
        endcase
    endfunction

    function automatic logic [2:0] pick_reg(input logic [2:0] bits, input logic wide);
        return wide ? bits : {1'b0, bits[1:0]};     // small pool makes dependencies likely
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [2:0]  d, s, t;
        for (int i = 0; i < 256; i++)
            prog[i] = 16'h0000;
        for (int i = 0; i < PROG_LEN - 8; i++) begin
            r = $random(seed);
            d = pick_reg(r[18:16], r[28]);
            s = pick_reg(r[21:19], r[29]);
            t = pick_reg(r[24:22], r[30]);
            case (r[3:0])
                4'd0, 4'd1: prog[i] = {4'h1, d, s, 3'b000, t};
                4'd2:       prog[i] = {4'h1, d, s, 3'b010, t};
                4'd3:       prog[i] = {4'h1, d, s, 3'b001, t};
                4'd4:       prog[i] = {4'h1, d, s, 1'b1, r[8:4]};
                4'd5:       prog[i] = {4'h5, d, s, 3'b000, t};
                4'd6:       prog[i] = {4'h5, d, s, 3'b010, t};
                4'd7:       prog[i] = {4'h5, d, s, 3'b011, t};
                4'd8, 4'd9: prog[i] = {4'h6, d, s, r[9:4]};
                4'd10, 4'd11: prog[i] = {4'h7, d, s, r[9:4]};
                4'd12, 4'd13: prog[i] = {4'h9, d, r[12:4]};
                default:    prog[i] = {4'h0, r[11:9], 7'd0, r[5:4]};   // forward 0 to 3
            endcase
        end
        prog[0]  = 16'h0E02;    // BRnzp +2 while NZP is still clear
        prog[20] = 16'h6681;    // LDR r3, r2, #1
        prog[21] = 16'h7682;    // STR r3, r2, #2 takes the load data over WM
        prog[22] = 16'h60C0;    // LDR r0, r3, #0
        prog[23] = 16'h1200;    // ADD r1, r0, r0 right behind the load
    endtask

    task automatic run_model();
        lc4_pipe_pkg::retire_t rec;
        logic                  taken, prev_taken, prev_load;
        logic [15:0]           insn;
        logic [2:0]            prev_rd;
        for (int i = 0; i < 8; i++)
            m_regs[i] = 16'h0000;
        for (int a = 0; a < 65536; a++)
            m_mem[a] = 16'h0000;
        m_nzp      = 3'b000;
        m_pc       = RESET_PC;
        prev_taken = 1'b0;
        prev_load  = 1'b0;
        prev_rd    = 3'd0;
        while (16'(m_pc - RESET_PC) < 16'(PROG_LEN)) begin
            insn = prog[8'(m_pc - RESET_PC)];
            exp_flush.push_back(prev_taken ? 2 : 0);
            exp_load.push_back((prev_load && reads_reg(insn, prev_rd)) ? 1 : 0);
            model_step(insn, rec, taken);
            exp_q.push_back(rec);
            prev_taken = taken;
            prev_load  = insn[15:12] == 4'h6;
            prev_rd    = insn[11:9];
        end
    endtask

    // waits for the next live retire record and counts the bubbles before it
    task automatic next_retire(output int flushes, output int loads, output int waited,
                               output bit found);
        flushes = 0;
        loads   = 0;
        waited  = 0;
        found   = 1'b0;
        while (!found && waited < RETIRE_TIMEOUT) begin
            @(negedge gwe);
            waited++;
            if (retire.stall == lc4_pipe_pkg::STALL_NONE)
                found = 1'b1;
            else if (retire.stall == lc4_pipe_pkg::STALL_FLUSH)
                flushes++;
            else
                loads++;
        end
    endtask

    initial begin
        lc4_pipe_pkg::retire_t e;
        int  flushes, loads, waited, total_chk, total_err;
        bit  found;
        string names [6];
        names = '{"alu and const results", "memory accesses", "branch path",
                  "load-use stalls", "nzp", "reset and latency"};
        i_rst     = 1'b1;
        seed      = 32'hab9b;
        timed_out = 1'b0;
        for (int a = 0; a < 65536; a++)
            dmem[a] = 16'h0000;
        build_program();
        run_model();

        repeat (16) begin
            @(negedge gwe);
            check_cond(5, !dmem_we, "data memory write enable high during reset");
            check_cond(5, !retire.rf_we && !retire.nzp_we && !retire.dmem_we,
                       "retire write enables high during reset");
        end
        i_rst = 1'b0;

        for (int k = 0; k < exp_q.size() && !timed_out; k++) begin
            e = exp_q[k];
            next_retire(flushes, loads, waited, found);
            if (!found) begin
                $display("error at %0t: pipeline stopped retiring before record %0d", $time, k);
                timed_out = 1'b1;
            end else begin
                if (k == 0) begin
                    check_val(5, "first pc", RESET_PC, retire.pc);
                    check_cond(5, waited == 5, "first retire not five edges after reset");
                end else begin
                    check_cond(2, flushes == exp_flush[k], "wrong number of flush bubbles");
                    check_cond(3, loads == exp_load[k], "wrong number of load bubbles");
                end
                if (k == 1)
                    check_cond(4, retire.pc == RESET_PC + 16'd1, "branch taken with nzp clear");
                check_val(2, "pc", e.pc, retire.pc);
                check_val(2, "insn", e.insn, retire.insn);
                check_val(e.insn[15:12] == 4'h6 ? 3 : 0, "rf_we", 16'(e.rf_we),
                          16'(retire.rf_we));
                if (e.rf_we) begin
                    check_val(0, "rf_wsel", 16'(e.rf_wsel), 16'(retire.rf_wsel));
                    check_val(e.insn[15:12] == 4'h6 ? 3 : 0, "rf_data", e.rf_data,
                              retire.rf_data);
                end
                check_val(4, "nzp_we", 16'(e.nzp_we), 16'(retire.nzp_we));
                check_val(4, "nzp", 16'(e.nzp), 16'(retire.nzp));
                check_val(1, "dmem_we", 16'(e.dmem_we), 16'(retire.dmem_we));
                check_val(1, "dmem_addr", e.dmem_addr, retire.dmem_addr);
                check_val(1, "dmem_data", e.dmem_data, retire.dmem_data);
            end
        end

        for (int a = 0; a < 65536; a++) begin
            if (dmem[a] !== m_mem[a])
                check_val(1, $sformatf("dmem[%h]", 16'(a)), m_mem[a], dmem[a]);
        end

        total_chk = 0;
        total_err = 0;
        for (int g = 0; g < 6; g++) begin
            $display("%-22s checks %0d errors %0d", names[g], grp_chk[g], grp_err[g]);
            total_chk += grp_chk[g];
            total_err += grp_err[g];
        end
        $display("total checks %0d errors %0d timeout %0d", total_chk, total_err, timed_out);
        if (total_err == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/lc4_isa_pkg.sv
common/lc4_pipe_pkg.sv
hw/lc4_decoder.sv
hw/lc4_alu.sv
hw/lc4_regfile.sv
lc4_core/lc4_hazard_unit.sv
lc4_core/lc4_core.sv
+incdir+verification
verification/lc4_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lc4_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module lc4_core_tb \
    -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vlc4_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
